// File: dma_xfer.f
+incdir+hw
hw/dma_reg_pkg.sv
hw/dma_xfer_pkg.sv
hw/dma_cnet_if.sv
hw/dma_apb_regs.sv
hw/dma_write_ctrl.sv
hw/dma_cnet_out.sv
hw/dma_xfer_top.sv
bench/tb_dma_xfer.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the DMA write engine testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dma_xfer -f dma_xfer.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_dma_xfer)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
   exit 0
fi
exit 1

// File: bench/dma_cases.txt
// Columns: ADDR SIZE MAC HOST_IS_LE TIMEOUT HOST_STALL STALL_FOREVER EXP_STATUS
// STATUS bits: 4 timeout, 3 addr_err, 2 size_err, 1 done, 0 busy
00001000 0010 3 0 10 0 0 02
00002040 0020 5 1 10 0 0 02
10000100 0040 a 0 10 1 0 02
20000200 0080 7 1 10 1 0 02
00003000 0000 1 0 10 0 0 06
00003000 0016 1 0 10 0 0 06
00003000 0804 1 0 10 0 0 06
00003002 0010 1 0 10 0 0 0a
00004000 0020 2 0 14 0 1 12
00005000 0008 9 1 10 1 0 02
00006000 0800 f 0 10 1 0 02
00003001 0006 4 0 10 0 0 0e

// File: bench/tb_dma_xfer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module tb_dma_xfer;

   localparam int MAX_CASES = 32;
   localparam int NCOL      = 8;                // Columns per case line

   logic                   clk;
   logic                   rst_n;
   logic [`DMA_APB_AW-1:0] paddr;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`DMA_DATA_W-1:0] pwdata;
   logic [`DMA_DATA_W-1:0] prdata;
   logic                   pready;
   logic                   pslverr;
   logic                   host_req;
   logic [`DMA_ADDR_W-1:0] host_addr;
   logic [`DMA_DATA_W-1:0] host_data;
   logic                   host_vld;
   logic [`DMA_DATA_W-1:0] cnet_data;
   logic                   cnet_wr_en;
   logic                   cnet_wr_rdy;
   logic                   intr;

   logic [31:0] cases_mem [0:MAX_CASES*NCOL-1];
   logic [31:0] exp_q [$];                      // Words the sink still expects
   logic [31:0] exp_w;
   integer      seed = 32'hb9e8;
   integer      errors = 0;
   integer      rx_count = 0;
   integer      budget = 0;                     // Watchdog length in cycles
   logic        cur_stall = 1'b0;
   logic        cur_never = 1'b0;
   logic        req_seen = 1'b0;

   dma_xfer_top dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .host_req    (host_req),
      .host_addr   (host_addr),
      .host_data   (host_data),
      .host_vld    (host_vld),
      .cnet_data   (cnet_data),
      .cnet_wr_en  (cnet_wr_en),
      .cnet_wr_rdy (cnet_wr_rdy),
      .intr        (intr)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;                    // 8 ns period
   end

   // Host memory content depends on every address bit
   function automatic logic [31:0] host_word(input logic [31:0] a);
      logic [15:0] hi;
      hi = a[15:0] ^ a[31:16];
      return {hi, ~hi};
   endfunction

   function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   function automatic bit is_legal(input logic [31:0] a, input logic [31:0] s);
      return (s[1:0] == 2'b00) && (s >= 32'd4) && (s <= `DMA_MAX_BYTES) && (a[1:0] == 2'b00);
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, got);
      errors = errors + 1;
   endtask

   // ======================================================================
   // APB master tasks start and end 1 ns after a rising edge
   // ======================================================================
   task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
      paddr   = a;
      pwdata  = d;
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;                           // Access phase
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
      paddr   = a;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);                           // Data settled by mid cycle
      d   = prdata;
      err = pslverr;
      if (pready !== 1'b1)
         report_mismatch("pready", 32'd1, 32'(pready));
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_for_intr(input integer limit, output bit ok);
      integer n;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < limit)
      begin
         @(negedge clk);
         if (intr === 1'b1)
            ok = 1'b1;
         n = n + 1;
      end
      @(posedge clk);
      #1;
   endtask

   // ======================================================================
   // Host model and CNET sink
   // ======================================================================
   initial
   begin : host_model
      integer wait_cyc;
      host_vld  = 1'b0;
      host_data = '0;
      forever
      begin
         @(posedge clk);
         #1;
         if (host_req === 1'b1 && !cur_never)
         begin
            wait_cyc = cur_stall ? ($random(seed) & 3) : 0;   // 0 to 3 cycles late
            repeat (wait_cyc)
            begin
               @(posedge clk);
               #1;
            end
            host_data = host_word(host_addr);
            host_vld  = 1'b1;
            @(posedge clk);
            #1;
            host_vld  = 1'b0;                   // host_req drops at this edge
         end
      end
   end

   initial
   begin : sink_drive
      cnet_wr_rdy = 1'b0;
      forever
      begin
         @(posedge clk);
         #1;
         cnet_wr_rdy = cur_stall ? (($random(seed) & 3) != 0) : 1'b1;
      end
   end

   always @(negedge clk)
   begin
      if (rst_n && cnet_wr_en && cnet_wr_rdy)   // Word moves at next edge
      begin
         rx_count = rx_count + 1;
         if (exp_q.size() == 0)
         begin
            $display("Unexpected CNET word %h at %0t", cnet_data, $time);
            errors = errors + 1;
         end
         else
         begin
            exp_w = exp_q.pop_front();
            if (cnet_data !== exp_w)
               report_mismatch("cnet_data", exp_w, cnet_data);
         end
      end
      if (rst_n && host_req === 1'b1)
         req_seen = 1'b1;
   end

   // ======================================================================
   // One case from the table
   // ======================================================================
   task automatic run_case(input integer idx, output bit ok);
      logic [31:0] addr, size, mac, le, tmo, stall, never, exp_st;
      logic [31:0] rd;
      logic        err;
      integer      words, exp_rx, i;
      bit          legal;
      addr   = cases_mem[idx*NCOL+0];
      size   = cases_mem[idx*NCOL+1];
      mac    = cases_mem[idx*NCOL+2];
      le     = cases_mem[idx*NCOL+3];
      tmo    = cases_mem[idx*NCOL+4];
      stall  = cases_mem[idx*NCOL+5];
      never  = cases_mem[idx*NCOL+6];
      exp_st = cases_mem[idx*NCOL+7];
      legal  = is_legal(addr, size);
      words  = legal ? size / 4 : 0;
      exp_q.delete();
      if (legal)
      begin
         exp_q.push_back({12'h000, mac[3:0], size[15:0]});   // Header is never swapped
         if (!never[0])
            for (i = 0; i < words; i++)
               exp_q.push_back(le[0] ? reverse_bytes(host_word(addr + 32'(4*i)))
                                     : host_word(addr + 32'(4*i)));
      end
      exp_rx    = exp_q.size();
      rx_count  = 0;
      req_seen  = 1'b0;
      cur_stall = stall[0];
      cur_never = never[0];

      apb_write(`DMA_OFF_ADDR, addr);
      apb_write(`DMA_OFF_SIZE, size);
      apb_write(`DMA_OFF_MAC, mac);
      apb_write(`DMA_OFF_TMO, tmo);
      apb_write(`DMA_OFF_CTRL, {29'b0, 1'b1, le[0], 1'b1});  // intr_en, endianness, go
      apb_read(`DMA_OFF_STATUS, rd, err);
      if (rd[0] !== 1'b1)
         report_mismatch("status.busy", 32'd1, {31'b0, rd[0]});
      if (legal)
         apb_write(`DMA_OFF_CTRL, {29'b0, 1'b1, ~le[0], 1'b1});  // Go with other endianness

      wait_for_intr(40 + 20*words + tmo, ok);
      if (!ok)
      begin
         $display("Case %0d never signalled done through intr", idx);
         errors = errors + 1;
      end
      else
      begin
         apb_read(`DMA_OFF_STATUS, rd, err);
         if (rd !== exp_st)
            report_mismatch("status", exp_st, rd);
         if (err !== 1'b0)
            report_mismatch("pslverr", 32'd0, 32'(err));
         if (intr !== 1'b1)
            report_mismatch("intr", 32'd1, 32'(intr));
         repeat (4) @(posedge clk);             // Nothing more may follow
         #1;
         if (rx_count != exp_rx)
            report_mismatch("cnet word count", exp_rx, rx_count);
         if (host_req !== 1'b0)
            report_mismatch("host_req", 32'd0, 32'(host_req));
         if (!legal && req_seen)
         begin
            $display("Case %0d raised host_req on an illegal request", idx);
            errors = errors + 1;
         end
         apb_write(`DMA_OFF_STATUS, 32'h0000_001e);   // Clear done and error bits
         apb_read(`DMA_OFF_STATUS, rd, err);
         if (rd !== 32'd0)
            report_mismatch("status after clear", 32'd0, rd);
         if (intr !== 1'b0)
            report_mismatch("intr after clear", 32'd0, 32'(intr));
         apb_read(8'h18, rd, err);              // Hole in the register map
         if (err !== 1'b1)
            report_mismatch("pslverr unmapped", 32'd1, 32'(err));
      end
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================
   initial
   begin : main
      integer n_cases, i, err_start, passed, failed, words;
      bit     ok;
      logic [31:0] rd;
      logic   err;
      rst_n   = 1'b0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      n_cases = 0;
      passed  = 0;
      failed  = 0;
      for (i = 0; i < MAX_CASES*NCOL; i++)
         cases_mem[i] = 32'hffff_ffff;          // End marker for unused lines
      $readmemh("bench/dma_cases.txt", cases_mem);
      budget = 100;                             // Reset and start up
      while (n_cases < MAX_CASES && cases_mem[n_cases*NCOL+1] != 32'hffff_ffff)
      begin
         words = is_legal(cases_mem[n_cases*NCOL], cases_mem[n_cases*NCOL+1])
                 ? cases_mem[n_cases*NCOL+1] / 4 : 0;
         budget = budget + 40 + 20*words + cases_mem[n_cases*NCOL+4];
         n_cases = n_cases + 1;
      end
      if (n_cases == 0)
      begin
         $display("No cases found in bench/dma_cases.txt");
         errors = errors + 1;
      end

      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      if (host_req !== 1'b0 || cnet_wr_en !== 1'b0 || intr !== 1'b0)
         report_mismatch("outputs after reset", 32'd0, {29'b0, host_req, cnet_wr_en, intr});
      apb_read(`DMA_OFF_STATUS, rd, err);
      if (rd !== 32'd0)
         report_mismatch("status after reset", 32'd0, rd);

      ok = 1'b1;
      for (i = 0; i < n_cases && ok; i++)
      begin
         err_start = errors;
         run_case(i, ok);
         if (errors == err_start)
            passed = passed + 1;
         else
            failed = failed + 1;
         $display("Case %0d addr %h size %0d: %s", i, cases_mem[i*NCOL],
                  cases_mem[i*NCOL+1], (errors == err_start) ? "pass" : "fail");
      end

      $display("Cases run %0d, passed %0d, failed %0d, errors %0d",
               passed + failed, passed, failed, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   initial
   begin : watchdog
      wait (budget > 0);
      #1;                                       // Let the case sum complete
      repeat (budget) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run did not finish", budget);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/dma_xfer_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_xfer_top (
   input  wire                      clk,
   input  wire                      rst_n,
   // APB slave
   input  wire [`DMA_APB_AW-1:0]    paddr,
   input  wire                      psel,
   input  wire                      penable,
   input  wire                      pwrite,
   input  wire [`DMA_DATA_W-1:0]    pwdata,
   output logic [`DMA_DATA_W-1:0]   prdata,
   output logic                     pready,
   output logic                     pslverr,
   // Host read port
   output logic                     host_req,
   output logic [`DMA_ADDR_W-1:0]   host_addr,
   input  wire [`DMA_DATA_W-1:0]    host_data,
   input  wire                      host_vld,
   // CNET write port
   output logic [`DMA_DATA_W-1:0]   cnet_data,
   output logic                     cnet_wr_en,
   input  wire                      cnet_wr_rdy,
   output logic                     intr
);

   dma_reg_pkg::req_t    req;
   dma_reg_pkg::status_t fin_status;
   logic                 start;
   logic                 fin;
   logic                 idle;

   dma_cnet_if cnet_if ();                      // Controller to output stage

   // ======================================================================
   // Register block
   // ======================================================================
   dma_apb_regs regs_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .paddr      (paddr),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .fin        (fin),
      .fin_status (fin_status),
      .req        (req),
      .start      (start),
      .intr       (intr)
   );

   dma_write_ctrl ctrl_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .start      (start),
      .host_data  (host_data),
      .host_vld   (host_vld),
      .host_req   (host_req),
      .host_addr  (host_addr),
      .cnet       (cnet_if.ctrl),
      .idle       (idle),
      .fin        (fin),
      .fin_status (fin_status)
   );

   dma_cnet_out out_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .cnet        (cnet_if.out),
      .cnet_data   (cnet_data),
      .cnet_wr_en  (cnet_wr_en),
      .cnet_wr_rdy (cnet_wr_rdy),
      .idle        (idle)
   );

endmodule

`default_nettype wire

// File: hw/dma_cnet_out.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_cnet_out (
   input  wire                     clk,
   input  wire                     rst_n,
   dma_cnet_if.out                 cnet,
   output logic [`DMA_DATA_W-1:0]  cnet_data,
   output logic                    cnet_wr_en,
   input  wire                     cnet_wr_rdy,
   output logic                    idle           // Nothing held, no packet open
);

   logic                   full_q;               // Register holds a word
   logic                   pkt_open_q;           // Header out, last word not yet
   logic [`DMA_DATA_W-1:0] data_q;
   logic                   take;

   assign cnet.ready = !full_q || cnet_wr_rdy;   // Empty, or emptying this cycle
   assign take       = cnet.valid && cnet.ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         full_q     <= 1'b0;
         pkt_open_q <= 1'b0;
      end
      else
      begin
         if (take)
            full_q <= 1'b1;
         else if (cnet_wr_rdy)
            full_q <= 1'b0;                      // Word left toward CNET
         if (take && cnet.kind == dma_xfer_pkg::WK_HDR)
            pkt_open_q <= 1'b1;
         else if (take && cnet.last)
            pkt_open_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
      if (take)
         data_q <= cnet.data;                    // Held while sink stalls

   assign cnet_data  = data_q;
   assign cnet_wr_en = full_q;
   assign idle       = !full_q && !pkt_open_q;

   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      cnet_wr_en && !cnet_wr_rdy |=> cnet_wr_en && $stable(cnet_data));

endmodule

`default_nettype wire

// File: hw/dma_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_write_ctrl (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire dma_reg_pkg::req_t    req,
   input  wire                       start,
   input  wire [`DMA_DATA_W-1:0]     host_data,
   input  wire                       host_vld,
   output logic                      host_req,
   output logic [`DMA_ADDR_W-1:0]    host_addr,
   dma_cnet_if.ctrl                  cnet,
   input  wire                       idle,        // Output stage empty
   output logic                      fin,
   output dma_reg_pkg::status_t      fin_status
);

   dma_xfer_pkg::state_e   state_q, state_d;
   dma_reg_pkg::req_t      req_q;              // Latched at start
   logic [`DMA_CNT_W-1:0]  cnt_q;              // Data words left
   logic [`DMA_ADDR_W-1:0] addr_q;
   logic [31:0]            tmr_q;              // Cycles spent waiting on host
   logic [`DMA_DATA_W-1:0] word_q;
   logic                   size_err_q, addr_err_q, tmo_q;
   logic                   size_bad, addr_bad, tmr_expired, last_word;

   // Reverse byte order of one word
   function automatic logic [`DMA_DATA_W-1:0] bswap(input logic [`DMA_DATA_W-1:0] d);
      logic [`DMA_DATA_W-1:0] r;
      for (int i = 0; i < `DMA_DATA_W/8; i++)
         r[8*i +: 8] = d[`DMA_DATA_W-8-8*i +: 8];
      return r;
   endfunction

   assign size_bad = (req_q.size[1:0] != 2'b00) || (req_q.size < 16'd4)
                     || (req_q.size > `DMA_MAX_BYTES);
   assign addr_bad = req_q.addr[1:0] != 2'b00;
   assign tmr_expired = (tmr_q + 32'd1) >= req_q.timeout;
   assign last_word = cnt_q == `DMA_CNT_W'(1);

   // ======================================================================
   // Next state
   // ======================================================================
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         dma_xfer_pkg::IDLE:   if (start) state_d = dma_xfer_pkg::CHECK;
         dma_xfer_pkg::CHECK:  state_d = (size_bad || addr_bad) ? dma_xfer_pkg::FINISH
                                                                : dma_xfer_pkg::HDR;
         dma_xfer_pkg::HDR:    if (cnet.ready) state_d = dma_xfer_pkg::FETCH;
         dma_xfer_pkg::FETCH:
         begin
            if (host_vld)
               state_d = dma_xfer_pkg::PUSH;
            else if (tmr_expired)
               state_d = dma_xfer_pkg::FINISH;  // Abort when the host gives up
         end
         dma_xfer_pkg::PUSH:   if (cnet.ready) state_d = last_word ? dma_xfer_pkg::DRAIN
                                                                   : dma_xfer_pkg::FETCH;
         dma_xfer_pkg::DRAIN:  if (idle) state_d = dma_xfer_pkg::FINISH;
         default:              state_d = dma_xfer_pkg::IDLE;   // FINISH too
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q    <= dma_xfer_pkg::IDLE;
         host_req   <= 1'b0;
         size_err_q <= 1'b0;
         addr_err_q <= 1'b0;
         tmo_q      <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         if (state_q == dma_xfer_pkg::FETCH && (host_vld || tmr_expired))
            host_req <= 1'b0;                  // Word taken or host timed out
         else if (state_d == dma_xfer_pkg::FETCH)
            host_req <= 1'b1;                  // Ask for the next host word
         if (state_q == dma_xfer_pkg::CHECK)
         begin
            size_err_q <= size_bad;
            addr_err_q <= addr_bad;
            tmo_q      <= 1'b0;
         end
         if (state_q == dma_xfer_pkg::FETCH && !host_vld && tmr_expired)
            tmo_q <= 1'b1;
      end
   end

   // Datapath
   always_ff @(posedge clk)
   begin
      if (state_q == dma_xfer_pkg::IDLE && start)
         req_q <= req;
      if (state_q == dma_xfer_pkg::CHECK)
      begin
         cnt_q  <= req_q.size[`DMA_CNT_W+1:2];  // Bytes to words
         addr_q <= req_q.addr;
      end
      else if (state_q == dma_xfer_pkg::PUSH && cnet.ready)
      begin
         cnt_q  <= cnt_q - 1'b1;
         addr_q <= addr_q + `DMA_ADDR_W'(4);
      end
      if (state_q != dma_xfer_pkg::FETCH)
         tmr_q <= '0;                          // Restart per host word
      else
         tmr_q <= tmr_q + 32'd1;
      if (state_q == dma_xfer_pkg::FETCH && host_vld)
         word_q <= req_q.host_is_le ? bswap(host_data) : host_data;
   end

   // ======================================================================
   // Outputs
   // ======================================================================
   assign host_addr  = addr_q;
   assign cnet.valid = (state_q == dma_xfer_pkg::HDR) || (state_q == dma_xfer_pkg::PUSH);
   assign cnet.kind  = (state_q == dma_xfer_pkg::HDR) ? dma_xfer_pkg::WK_HDR
                                                      : dma_xfer_pkg::WK_DATA;
   assign cnet.data  = (state_q == dma_xfer_pkg::HDR)
                       ? {{(`DMA_DATA_W-20){1'b0}}, req_q.mac, req_q.size}   // Never swapped
                       : word_q;
   assign cnet.last  = (state_q == dma_xfer_pkg::PUSH) && last_word;
   assign fin        = state_q == dma_xfer_pkg::FINISH;

   always_comb
   begin
      fin_status          = '0;
      fin_status.done     = 1'b1;
      fin_status.size_err = size_err_q;
      fin_status.addr_err = addr_err_q;
      fin_status.timeout  = tmo_q;
   end

   a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      host_req && $past(host_req) |-> $stable(host_addr));
   a_req_fetch: assert property (@(posedge clk) disable iff (!rst_n)
      host_req |-> state_q == dma_xfer_pkg::FETCH);

endmodule

`default_nettype wire

// File: hw/dma_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_apb_regs (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire [`DMA_APB_AW-1:0]    paddr,
   input  wire                      psel,
   input  wire                      penable,
   input  wire                      pwrite,
   input  wire [`DMA_DATA_W-1:0]    pwdata,
   output logic [`DMA_DATA_W-1:0]   prdata,
   output logic                     pready,
   output logic                     pslverr,
   input  wire                      fin,          // Controller finished
   input  wire dma_reg_pkg::status_t fin_status,  // Result flags with fin
   output dma_reg_pkg::req_t        req,
   output logic                     start,
   output logic                     intr
);

   logic [`DMA_ADDR_W-1:0] addr_q;
   logic [15:0]            size_q;
   logic [3:0]             mac_q;
   logic [31:0]            tmo_q;
   dma_reg_pkg::ctrl_t     ctrl_q;
   dma_reg_pkg::status_t   status_q;
   logic                   mapped;
   logic                   wr_en;
   logic                   go_ok;

   // ======================================================================
   // APB decode
   // ======================================================================
   assign wr_en  = psel && penable && pwrite;   // Access phase write
   assign go_ok  = wr_en && (paddr == dma_reg_pkg::CTRL) && pwdata[0] && !status_q.busy;
   assign pready = 1'b1;                        // No wait states
   assign pslverr = psel && penable && !mapped;

   always_comb
   begin
      prdata = '0;
      mapped = 1'b1;
      case (paddr)
         dma_reg_pkg::ADDR:    prdata = addr_q;
         dma_reg_pkg::SIZE:    prdata[15:0] = size_q;
         dma_reg_pkg::MAC:     prdata[3:0] = mac_q;
         dma_reg_pkg::CTRL:    prdata[2:0] = ctrl_q;
         dma_reg_pkg::STATUS:  prdata[4:0] = status_q;
         dma_reg_pkg::TIMEOUT: prdata = tmo_q;
         default:              mapped = 1'b0;   // Hole in the map
      endcase
   end

   // ======================================================================
   // Registers and status
   // ======================================================================
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         addr_q   <= '0;
         size_q   <= '0;
         mac_q    <= '0;
         tmo_q    <= '0;
         ctrl_q   <= '0;
         status_q <= '0;
      end
      else
      begin
         ctrl_q.go <= go_ok;                    // One cycle start pulse
         if (wr_en)
         begin
            case (paddr)
               dma_reg_pkg::ADDR:    addr_q <= pwdata;
               dma_reg_pkg::SIZE:    size_q <= pwdata[15:0];
               dma_reg_pkg::MAC:     mac_q  <= pwdata[3:0];
               dma_reg_pkg::TIMEOUT: tmo_q  <= pwdata;
               dma_reg_pkg::CTRL:
               begin
                  ctrl_q.host_is_le <= pwdata[1];
                  ctrl_q.intr_en    <= pwdata[2];
               end
               dma_reg_pkg::STATUS:  // Write 1 to clear, busy untouched
                  status_q <= status_q & ~dma_reg_pkg::status_t'({pwdata[4:1], 1'b0});
               default: ;
            endcase
         end
         if (go_ok)
         begin
            status_q      <= '0;                // New transfer wipes old result
            status_q.busy <= 1'b1;
         end
         if (fin)
            status_q <= fin_status;             // busy low, done high
      end
   end

   assign start = ctrl_q.go;
   assign intr  = status_q.done && ctrl_q.intr_en;

   assign req.addr       = addr_q;
   assign req.size       = size_q;
   assign req.mac        = mac_q;
   assign req.host_is_le = ctrl_q.host_is_le;
   assign req.timeout    = tmo_q;

   // Controller only finishes a transfer that was started here
   a_fin_busy: assert property (@(posedge clk) disable iff (!rst_n)
      fin |-> status_q.busy);

endmodule

`default_nettype wire

// File: hw/dma_cnet_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

// Word handshake between controller and CNET output register
interface dma_cnet_if;

   logic [`DMA_DATA_W-1:0]   data;
   dma_xfer_pkg::word_kind_e kind;      // Header or data word
   logic                     valid;
   logic                     ready;
   logic                     last;      // Final data word of the packet

   modport ctrl (
      output data, kind, valid, last,
      input  ready
   );

   modport out (
      input  data, kind, valid, last,
      output ready
   );

endinterface

`default_nettype wire

// File: hw/dma_xfer_pkg.sv
`default_nettype none

package dma_xfer_pkg;

   // Write engine states
   typedef enum logic [2:0] {
      IDLE,                             // Wait for start
      CHECK,                            // Legality of addr and size
      HDR,                              // Offer header word
      FETCH,                            // Wait for host word
      PUSH,                             // Offer data word
      DRAIN,                            // Wait for output stage to empty
      FINISH                            // Report result
   } state_e;

   // Tag on each word toward the CNET
   typedef enum logic {
      WK_HDR,
      WK_DATA
   } word_kind_e;

endpackage

`default_nettype wire

// File: hw/dma_reg_pkg.sv
`default_nettype none
`include "dma_cfg.svh"

package dma_reg_pkg;

   // Register offsets seen by software
   typedef enum logic [`DMA_APB_AW-1:0] {
      ADDR    = `DMA_OFF_ADDR,
      SIZE    = `DMA_OFF_SIZE,
      MAC     = `DMA_OFF_MAC,
      CTRL    = `DMA_OFF_CTRL,
      STATUS  = `DMA_OFF_STATUS,
      TIMEOUT = `DMA_OFF_TMO
   } reg_off_e;

   typedef struct packed {
      logic intr_en;                    // Bit 2
      logic host_is_le;                 // Bit 1
      logic go;                         // Bit 0, self clearing
   } ctrl_t;

   typedef struct packed {
      logic timeout;                    // Bit 4
      logic addr_err;                   // Bit 3
      logic size_err;                   // Bit 2
      logic done;                       // Bit 1
      logic busy;                       // Bit 0, read only
   } status_t;

   // Transfer request handed to the controller
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [15:0]            size;     // Bytes
      logic [3:0]             mac;
      logic                   host_is_le;
      logic [31:0]            timeout;  // Cycles per host word
   } req_t;

endpackage

`default_nettype wire

// File: hw/dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Datapath widths
`define DMA_DATA_W     32          // Host and CNET word
`define DMA_ADDR_W     32          // Host byte address
`define DMA_CNT_W      10          // Word counter, up to 512 words
`define DMA_MAX_BYTES  2048        // Largest legal packet

// APB register map
`define DMA_APB_AW     8
`define DMA_OFF_ADDR   8'h00
`define DMA_OFF_SIZE   8'h04
`define DMA_OFF_MAC    8'h08
`define DMA_OFF_CTRL   8'h0C
`define DMA_OFF_STATUS 8'h10
`define DMA_OFF_TMO    8'h14

`endif
